//--- rtl/spmm_pkg.sv
package spmm_pkg;

  // ====================================================================
  // Sizes
  // ====================================================================
  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 16;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int HALF_OUT        = NUM_FEATURE_OUT / 2;
  localparam int NUM_ROWS        = 12;
  localparam int MAX_NODES       = 8;
  localparam int H_DEPTH         = 64;

  // Derived widths
  localparam int COL_IDX_WIDTH        = $clog2(NUM_FEATURE_IN);
  // Row length runs 0 to NUM_FEATURE_IN inclusive
  localparam int ROW_LEN_WIDTH        = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_WIDTH       = $clog2(MAX_NODES);
  localparam int H_ADDR_WIDTH         = $clog2(H_DEPTH);
  localparam int NODE_INFO_ADDR_WIDTH = $clog2(NUM_ROWS);
  localparam int WH_ADDR_WIDTH        = $clog2(NUM_ROWS);

  // ====================================================================
  // Record types
  // ====================================================================
  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;

  // One nonzero of H
  typedef struct packed {
    logic [COL_IDX_WIDTH-1:0] col_idx;
    data_t                    val;
  } h_elem_t;

  // One row descriptor of H
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]  row_len;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } node_info_t;

  typedef data_t    [NUM_FEATURE_OUT-1:0] wgt_row_t;
  typedef data_t    [HALF_OUT-1:0]        half_wgt_t;
  typedef wh_data_t [HALF_OUT-1:0]        half_res_t;

  // Column 0 sits in the lowest slot of res
  typedef struct packed {
    wh_data_t [NUM_FEATURE_OUT-1:0] res;
    logic [NUM_NODE_WIDTH-1:0]      num_node;
    logic                           src_flag;
  } wh_word_t;

endpackage

//--- rtl/spmm_elem_if.sv
`timescale 1ns/100ps

interface spmm_elem_if;

  // Element strobe and payload
  logic                                vld;
  spmm_pkg::data_t                     val;
  logic                                last;

  // Row info, valid together with the element
  logic [spmm_pkg::NUM_NODE_WIDTH-1:0] num_node;
  logic                                src_flag;

  modport src (
    output vld,
    output val,
    output last,
    output num_node,
    output src_flag
  );

  modport sink (
    input vld,
    input val,
    input last,
    input num_node,
    input src_flag
  );

endinterface

//--- rtl/spmm_row_fetch.sv
`timescale 1ns/100ps

module spmm_row_fetch (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start_i,
  output logic [spmm_pkg::NODE_INFO_ADDR_WIDTH-1:0] node_info_addr_o,
  input  spmm_pkg::node_info_t                      node_info_i,
  output logic [spmm_pkg::H_ADDR_WIDTH-1:0]         h_addr_o,
  input  spmm_pkg::h_elem_t                         h_elem_i,
  output logic [spmm_pkg::COL_IDX_WIDTH-1:0]        wgt_addr_o,
  spmm_elem_if.src                                  elem
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_INFO_REQ,
    S_INFO,
    S_STREAM
  } state_t;

  state_t                                    state_q;
  logic [spmm_pkg::NODE_INFO_ADDR_WIDTH-1:0] row_cnt_q;
  logic [spmm_pkg::ROW_LEN_WIDTH-1:0]        elem_cnt_q;
  logic [spmm_pkg::H_ADDR_WIDTH-1:0]         h_addr_q;
  spmm_pkg::node_info_t                      row_info_q;

  // Read stage, nonzero data returns in the next cycle
  logic                                      rd_vld_q;
  logic                                      rd_last_q;
  logic                                      rd_zero_q;

  // Element stage, lines up with the returned weight row
  logic                                      vld_q;
  logic                                      last_q;
  spmm_pkg::data_t                           val_q;
  logic [spmm_pkg::NUM_NODE_WIDTH-1:0]       num_node_q;
  logic                                      src_flag_q;

  logic                                      row_empty;
  logic                                      row_last;
  logic                                      last_row;

  assign row_empty = (row_info_q.row_len == '0);
  assign row_last  = row_empty ||
                     (elem_cnt_q == row_info_q.row_len - spmm_pkg::ROW_LEN_WIDTH'(1));
  assign last_row  = (row_cnt_q ==
                      spmm_pkg::NODE_INFO_ADDR_WIDTH'(spmm_pkg::NUM_ROWS - 1));

  // ====================================================================
  // Row walker FSM
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      row_cnt_q  <= '0;
      elem_cnt_q <= '0;
      h_addr_q   <= '0;
      rd_vld_q   <= 1'b0;
      rd_last_q  <= 1'b0;
      rd_zero_q  <= 1'b0;
      vld_q      <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      rd_vld_q  <= 1'b0;
      rd_last_q <= 1'b0;
      rd_zero_q <= 1'b0;
      vld_q     <= rd_vld_q;
      last_q    <= rd_last_q;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            row_cnt_q <= '0;
            h_addr_q  <= '0;
            state_q   <= S_INFO_REQ;
          end
        end
        // Node info address is out, data follows
        S_INFO_REQ: begin
          state_q <= S_INFO;
        end
        S_INFO: begin
          elem_cnt_q <= '0;
          state_q    <= S_STREAM;
        end
        S_STREAM: begin
          rd_vld_q  <= 1'b1;
          rd_last_q <= row_last;
          rd_zero_q <= row_empty;
          // Empty rows consume no nonzero entry
          if (!row_empty) begin
            h_addr_q <= h_addr_q + 1'b1;
          end
          if (row_last) begin
            elem_cnt_q <= '0;
            if (last_row) begin
              row_cnt_q <= '0;
              state_q   <= S_IDLE;
            end else begin
              row_cnt_q <= row_cnt_q + 1'b1;
              state_q   <= S_INFO_REQ;
            end
          end else begin
            elem_cnt_q <= elem_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // ====================================================================
  // Payload registers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (state_q == S_INFO) begin
      row_info_q <= node_info_i;
    end
    val_q      <= rd_zero_q ? '0 : h_elem_i.val;
    num_node_q <= row_info_q.num_node;
    src_flag_q <= row_info_q.src_flag;
  end

  assign node_info_addr_o = row_cnt_q;
  assign h_addr_o         = h_addr_q;
  // Weight row requested straight from the column just read
  assign wgt_addr_o       = rd_zero_q ? '0 : h_elem_i.col_idx;

  assign elem.vld      = vld_q;
  assign elem.val      = val_q;
  assign elem.last     = last_q;
  assign elem.num_node = num_node_q;
  assign elem.src_flag = src_flag_q;

endmodule

//--- rtl/spmm_pe_group.sv
`timescale 1ns/100ps

module spmm_pe_group #(
  parameter int NUM_LANES = spmm_pkg::HALF_OUT
) (
  input  logic                clk,
  input  logic                rst_n,
  spmm_elem_if.sink           elem,
  input  spmm_pkg::half_wgt_t wgt_i,
  output logic                res_vld_o,
  output spmm_pkg::half_res_t res_o
);

  spmm_pkg::wh_data_t acc_q [NUM_LANES];
  spmm_pkg::wh_data_t sum   [NUM_LANES];

  // ====================================================================
  // Multiply-accumulate lanes
  // ====================================================================
  // Products and sums wrap to WH_DATA_WIDTH
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      sum[i] = acc_q[i] + $signed(elem.val) * $signed(wgt_i[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_o <= 1'b0;
      for (int i = 0; i < NUM_LANES; i++) begin
        acc_q[i] <= '0;
      end
    end else begin
      res_vld_o <= elem.vld && elem.last;
      if (elem.vld) begin
        for (int i = 0; i < NUM_LANES; i++) begin
          // Start the next row from zero
          acc_q[i] <= elem.last ? '0 : sum[i];
        end
      end
    end
  end

  // Final sum includes the product of the last element
  always_ff @(posedge clk) begin
    if (elem.vld && elem.last) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        res_o[i] <= sum[i];
      end
    end
  end

endmodule

//--- rtl/spmm_wh_writer.sv
`timescale 1ns/100ps

module spmm_wh_writer (
  input  logic                               clk,
  input  logic                               rst_n,
  spmm_elem_if.sink                          elem,
  input  logic                               lo_vld_i,
  input  spmm_pkg::half_res_t                lo_res_i,
  input  spmm_pkg::half_res_t                hi_res_i,
  output logic                               wh_we_o,
  output logic [spmm_pkg::WH_ADDR_WIDTH-1:0] wh_addr_o,
  output spmm_pkg::wh_word_t                 wh_data_o,
  output logic                               done_o
);

  logic [spmm_pkg::NUM_NODE_WIDTH-1:0] num_node_q;
  logic                                src_flag_q;
  logic                                we_q;
  logic                                done_q;
  logic [spmm_pkg::WH_ADDR_WIDTH-1:0]  addr_q;
  spmm_pkg::wh_word_t                  word_q;
  logic                                last_addr;

  assign last_addr = (addr_q == spmm_pkg::WH_ADDR_WIDTH'(spmm_pkg::NUM_ROWS - 1));

  // ====================================================================
  // Word assembly
  // ====================================================================
  always_ff @(posedge clk) begin
    // Row info is held until the group results arrive
    if (elem.vld && elem.last) begin
      num_node_q <= elem.num_node;
      src_flag_q <= elem.src_flag;
    end
    if (lo_vld_i) begin
      word_q.res      <= {hi_res_i, lo_res_i};
      word_q.num_node <= num_node_q;
      word_q.src_flag <= src_flag_q;
    end
  end

  // ====================================================================
  // Write address and completion
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q   <= 1'b0;
      done_q <= 1'b0;
      addr_q <= '0;
    end else begin
      we_q   <= lo_vld_i;
      done_q <= we_q && last_addr;
      // Advance after each write, wrap after the final row
      if (we_q) begin
        addr_q <= last_addr ? '0 : addr_q + 1'b1;
      end
    end
  end

  assign wh_we_o   = we_q;
  assign wh_addr_o = addr_q;
  assign wh_data_o = word_q;
  assign done_o    = done_q;

endmodule

//--- rtl/spmm_top.sv
`timescale 1ns/100ps

module spmm_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start_i,

  // Node info memory
  output logic [spmm_pkg::NODE_INFO_ADDR_WIDTH-1:0] node_info_addr_o,
  input  spmm_pkg::node_info_t                      node_info_i,

  // Packed nonzero memory
  output logic [spmm_pkg::H_ADDR_WIDTH-1:0]         h_addr_o,
  input  spmm_pkg::h_elem_t                         h_elem_i,

  // Weight rows
  output logic [spmm_pkg::COL_IDX_WIDTH-1:0]        wgt_addr_o,
  input  spmm_pkg::wgt_row_t                        wgt_row_i,

  // WH memory write port
  output logic                                      wh_we_o,
  output logic [spmm_pkg::WH_ADDR_WIDTH-1:0]        wh_addr_o,
  output spmm_pkg::wh_word_t                        wh_data_o,
  output logic                                      done_o
);

  spmm_pkg::half_res_t lo_res;
  spmm_pkg::half_res_t hi_res;
  logic                lo_vld;

  spmm_elem_if u_elem_if ();

  // ====================================================================
  // Element source
  // ====================================================================
  spmm_row_fetch u_row_fetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .node_info_addr_o (node_info_addr_o),
    .node_info_i      (node_info_i),
    .h_addr_o         (h_addr_o),
    .h_elem_i         (h_elem_i),
    .wgt_addr_o       (wgt_addr_o),
    .elem             (u_elem_if.src)
  );

  // ====================================================================
  // PE groups, one per half of the output columns
  // ====================================================================
  // Columns 0 and 1
  spmm_pe_group #(
    .NUM_LANES (spmm_pkg::HALF_OUT)
  ) u_pe_lo (
    .clk       (clk),
    .rst_n     (rst_n),
    .elem      (u_elem_if.sink),
    .wgt_i     (wgt_row_i[spmm_pkg::HALF_OUT-1:0]),
    .res_vld_o (lo_vld),
    .res_o     (lo_res)
  );

  // Columns 2 and 3, strobes in step with the low group
  spmm_pe_group #(
    .NUM_LANES (spmm_pkg::HALF_OUT)
  ) u_pe_hi (
    .clk       (clk),
    .rst_n     (rst_n),
    .elem      (u_elem_if.sink),
    .wgt_i     (wgt_row_i[spmm_pkg::NUM_FEATURE_OUT-1:spmm_pkg::HALF_OUT]),
    .res_vld_o (),
    .res_o     (hi_res)
  );

  spmm_wh_writer u_wh_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .elem      (u_elem_if.sink),
    .lo_vld_i  (lo_vld),
    .lo_res_i  (lo_res),
    .hi_res_i  (hi_res),
    .wh_we_o   (wh_we_o),
    .wh_addr_o (wh_addr_o),
    .wh_data_o (wh_data_o),
    .done_o    (done_o)
  );

endmodule

//--- bench/spmm_clk_gen.sv
`timescale 1ns/100ps

module spmm_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset released just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- bench/spmm_checker.sv
`timescale 1ns/100ps

module spmm_checker (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               wh_we_i,
  input logic [spmm_pkg::WH_ADDR_WIDTH-1:0] wh_addr_i,
  input logic                               done_i
);

  // ====================================================================
  // Top-level strobe rules
  // ====================================================================
  // Done follows the final write, never shares its cycle
  a_we_done_apart: assert property (
    @(posedge clk) disable iff (!rst_n) !(wh_we_i && done_i)
  ) else $error("write strobe and done high in the same cycle");

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done_i |=> !done_i
  ) else $error("done held high for more than one cycle");

  // Only rows 0 to NUM_ROWS-1 exist
  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n) wh_we_i |-> (wh_addr_i < spmm_pkg::NUM_ROWS)
  ) else $error("WH write address outside the row range");

endmodule

//--- bench/spmm_tb.sv
`timescale 1ns/100ps

module spmm_tb;

  localparam int NUM_JOBS     = 4;
  localparam int DONE_TIMEOUT = 1000;
  localparam int NI_DEPTH     = 1 << spmm_pkg::NODE_INFO_ADDR_WIDTH;

  logic                                      clk;
  logic                                      rst_n;
  logic                                      start_i;
  logic [spmm_pkg::NODE_INFO_ADDR_WIDTH-1:0] node_info_addr_o;
  spmm_pkg::node_info_t                      node_info_i;
  logic [spmm_pkg::H_ADDR_WIDTH-1:0]         h_addr_o;
  spmm_pkg::h_elem_t                         h_elem_i;
  logic [spmm_pkg::COL_IDX_WIDTH-1:0]        wgt_addr_o;
  spmm_pkg::wgt_row_t                        wgt_row_i;
  logic                                      wh_we_o;
  logic [spmm_pkg::WH_ADDR_WIDTH-1:0]        wh_addr_o;
  spmm_pkg::wh_word_t                        wh_data_o;
  logic                                      done_o;

  // Memory models and the expected results
  spmm_pkg::node_info_t node_info_mem [NI_DEPTH];
  spmm_pkg::h_elem_t    h_mem         [spmm_pkg::H_DEPTH];
  spmm_pkg::wgt_row_t   wgt_mem       [spmm_pkg::NUM_FEATURE_IN];
  spmm_pkg::wh_word_t   wh_mem        [spmm_pkg::NUM_ROWS];
  spmm_pkg::wh_word_t   exp_word      [spmm_pkg::NUM_ROWS];

  // Read addresses sampled mid-cycle
  logic [spmm_pkg::NODE_INFO_ADDR_WIDTH-1:0] ni_addr_s;
  logic [spmm_pkg::H_ADDR_WIDTH-1:0]         h_addr_s;
  logic [spmm_pkg::COL_IDX_WIDTH-1:0]        wgt_addr_s;

  int unsigned seed;
  int          wr_cnt;
  int          done_cnt;
  logic        run_active;
  logic        we_prev;

  spmm_clk_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (10)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spmm_top dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .node_info_addr_o (node_info_addr_o),
    .node_info_i      (node_info_i),
    .h_addr_o         (h_addr_o),
    .h_elem_i         (h_elem_i),
    .wgt_addr_o       (wgt_addr_o),
    .wgt_row_i        (wgt_row_i),
    .wh_we_o          (wh_we_o),
    .wh_addr_o        (wh_addr_o),
    .wh_data_o        (wh_data_o),
    .done_o           (done_o)
  );

  bind spmm_top spmm_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_we_i   (wh_we_o),
    .wh_addr_i (wh_addr_o),
    .done_i    (done_o)
  );

  // ====================================================================
  // Reporting and compare tasks
  // ====================================================================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_wh_word(input spmm_pkg::wh_word_t act, input spmm_pkg::wh_word_t exp,
                               input int row);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at time %0d ns: row %0d word %h, expected %h",
                              $time, row, act, exp));
    end
  endtask

  task automatic check_addr(input logic [spmm_pkg::WH_ADDR_WIDTH-1:0] act,
                            input logic [spmm_pkg::WH_ADDR_WIDTH-1:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch at time %0d ns: WH write address %0d, expected %0d",
                              $time, act, exp));
    end
  endtask

  // ====================================================================
  // Memory models with data one cycle after the address
  // ====================================================================
  always @(negedge clk) begin
    ni_addr_s  = node_info_addr_o;
    h_addr_s   = h_addr_o;
    wgt_addr_s = wgt_addr_o;
  end

  always @(posedge clk) begin
    #1;
    node_info_i = node_info_mem[ni_addr_s];
    h_elem_i    = h_mem[h_addr_s];
    wgt_row_i   = wgt_mem[wgt_addr_s];
  end

  // WH write port and done monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (wh_we_o) begin
        if (!run_active || wr_cnt >= spmm_pkg::NUM_ROWS) begin
          stop_on_error("WH write seen while no row result was due");
        end
        check_addr(wh_addr_o, spmm_pkg::WH_ADDR_WIDTH'(wr_cnt));
        wh_mem[wh_addr_o] = wh_data_o;
        wr_cnt++;
      end
      if (done_o) begin
        if (!run_active || wr_cnt != spmm_pkg::NUM_ROWS || !we_prev) begin
          stop_on_error("done pulse not one cycle after the final WH write");
        end
        run_active = 1'b0;
        done_cnt++;
      end
      we_prev = wh_we_o;
    end
  end

  // ====================================================================
  // Random graph and reference sums
  // ====================================================================
  task automatic build_graph(input bit with_edges);
    int total;
    int len;
    int acc;
    int j;
    int tmp;
    int perm [spmm_pkg::NUM_FEATURE_IN];
    total = 0;
    for (int c = 0; c < spmm_pkg::NUM_FEATURE_IN; c++) begin
      for (int k = 0; k < spmm_pkg::NUM_FEATURE_OUT; k++) begin
        wgt_mem[c][k] = spmm_pkg::data_t'($urandom);
      end
    end
    for (int a = 0; a < spmm_pkg::H_DEPTH; a++) begin
      h_mem[a] = spmm_pkg::h_elem_t'($urandom);
    end
    for (int r = 0; r < NI_DEPTH; r++) begin
      node_info_mem[r] = spmm_pkg::node_info_t'($urandom);
    end
    for (int r = 0; r < spmm_pkg::NUM_ROWS; r++) begin
      // Edge graph has rows 2 and 7 empty and rows 4 and 10 full
      if (with_edges && (r == 2 || r == 7)) begin
        len = 0;
      end else if (with_edges && (r == 4 || r == 10)) begin
        len = spmm_pkg::NUM_FEATURE_IN;
      end else if (with_edges) begin
        len = $urandom_range(2, 0);
      end else begin
        len = $urandom_range(8, 0);
      end
      if (total + len > spmm_pkg::H_DEPTH) begin
        len = spmm_pkg::H_DEPTH - total;
      end
      node_info_mem[r].row_len = spmm_pkg::ROW_LEN_WIDTH'(len);
      // Distinct columns from a shuffled column list
      for (int i = 0; i < spmm_pkg::NUM_FEATURE_IN; i++) begin
        perm[i] = i;
      end
      for (int i = spmm_pkg::NUM_FEATURE_IN - 1; i > 0; i--) begin
        j       = $urandom_range(i, 0);
        tmp     = perm[i];
        perm[i] = perm[j];
        perm[j] = tmp;
      end
      for (int k = 0; k < len; k++) begin
        h_mem[total + k].col_idx = spmm_pkg::COL_IDX_WIDTH'(perm[k]);
      end
      exp_word[r].num_node = node_info_mem[r].num_node;
      exp_word[r].src_flag = node_info_mem[r].src_flag;
      for (int c = 0; c < spmm_pkg::NUM_FEATURE_OUT; c++) begin
        acc = 0;
        for (int k = 0; k < len; k++) begin
          acc += int'($signed(h_mem[total + k].val)) * int'($signed(wgt_mem[perm[k]][c]));
        end
        // Two's complement wrap to the result width
        exp_word[r].res[c] = spmm_pkg::wh_data_t'(acc);
      end
      total += len;
    end
  endtask

  // ====================================================================
  // Job sequencing
  // ====================================================================
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 50) begin
        stop_on_error("timeout waiting for reset release");
      end
    end
  endtask

  task automatic wait_done(input int target);
    int cycles;
    cycles = 0;
    while (done_cnt < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > DONE_TIMEOUT) begin
        stop_on_error("timeout waiting for the done pulse");
      end
    end
  endtask

  task automatic run_job(input bit with_edges);
    int target;
    build_graph(with_edges);
    target = done_cnt + 1;
    @(posedge clk);
    #1;
    wr_cnt     = 0;
    run_active = 1'b1;
    start_i    = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    wait_done(target);
    // Quiet cycles so that a late strobe reaches the monitor
    repeat (5) @(posedge clk);
    for (int r = 0; r < spmm_pkg::NUM_ROWS; r++) begin
      check_wh_word(wh_mem[r], exp_word[r], r);
    end
  endtask

  initial begin
    seed        = $urandom(32'hf6ca);
    start_i     = 1'b0;
    node_info_i = '0;
    h_elem_i    = '0;
    wgt_row_i   = '0;
    ni_addr_s   = '0;
    h_addr_s    = '0;
    wgt_addr_s  = '0;
    wr_cnt      = 0;
    done_cnt    = 0;
    run_active  = 1'b0;
    we_prev     = 1'b0;
    wait_reset_release();
    // Idle window where the monitor flags any strobe without a start
    repeat (20) @(posedge clk);
    for (int job = 0; job < NUM_JOBS; job++) begin
      run_job(job == 1);
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- verilog.f
rtl/spmm_pkg.sv
rtl/spmm_elem_if.sv
rtl/spmm_row_fetch.sv
rtl/spmm_pe_group.sv
rtl/spmm_wh_writer.sv
rtl/spmm_top.sv
bench/spmm_clk_gen.sv
bench/spmm_checker.sv
bench/spmm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the SpMM testbench, exit status reflects the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module spmm_tb \
       -Mdir obj_dir -f verilog.f \
  && ./obj_dir/Vspmm_tb \
  || exit 1
